// ==== common/perfCounterPkg.sv ====
// Shared types for the counter CSR unit; XLEN fixed at 32, 16 counters, event mapping fixed in RTL

package perfCounterPkg;

  ////////////////////
  // Sizes
  ////////////////////
  localparam int Xlen        = 32;                   // Register width
  localparam int NumCounters = 16;                   // Implemented counters 0..15
  localparam int CounterIdxW = $clog2(NumCounters);  // Bits to pick one counter

  typedef logic [11:0]            csrAdr_t;       // CSR address
  typedef logic [Xlen-1:0]        csrData_t;      // CSR data
  typedef logic [63:0]            counterVal_t;   // Full 64-bit count
  typedef logic [NumCounters-1:0] counterMask_t;  // One bit per counter
  typedef logic [1:0]             privMode_t;     // Privilege mode

  // Privilege encodings
  localparam privMode_t MMode = 2'd3;
  localparam privMode_t SMode = 2'd1;
  localparam privMode_t UMode = 2'd0;

  ////////////////////
  // CSR map
  ////////////////////
  localparam csrAdr_t MhpmCounterBase  = 12'hB00;  // mcycle, minstret, mhpmcounterN
  localparam csrAdr_t MhpmCounterHBase = 12'hB80;  // Upper halves
  localparam csrAdr_t HpmCounterBase   = 12'hC00;  // User read-only shadows
  localparam csrAdr_t HpmCounterHBase  = 12'hC80;
  localparam csrAdr_t TimeAdr          = 12'hC01;  // Shadow of platform mtime
  localparam csrAdr_t TimeHAdr         = 12'hC81;

  localparam csrAdr_t MCountInhibitAdr = 12'h320;
  localparam csrAdr_t MCounterEnAdr    = 12'h306;
  localparam csrAdr_t SCounterEnAdr    = 12'h106;

  // CSR access as seen in the memory stage
  typedef struct packed {
    logic      write;     // Write strobe, one cycle
    csrAdr_t   adr;
    csrData_t  writeVal;
    privMode_t privMode;  // Current privilege
  } csrReq_t;

  // Memory-stage event strobes
  typedef struct packed {
    logic       instrValidNotFlushed;
    logic       dirPredWrong;    // Direction predictor miss
    logic       btbPredPcWrong;  // BTB target miss
    logic       rasPredPcWrong;  // Return stack miss
    logic       classPredWrong;  // Instruction class mispredicted
    logic [4:0] instrClass;
    logic       dCacheAccess;
    logic       dCacheMiss;
    logic       iCacheAccess;
    logic       iCacheMiss;
  } pipeEvents_t;

  typedef struct packed {
    logic stallE;
    logic stallM;
    logic flushM;
    logic loadStallD;  // Load-use stall raised in decode
  } pipeCtrl_t;

  // Counter control registers
  typedef struct packed {
    counterMask_t inhibit;  // mcountinhibit
    counterMask_t mEnable;  // mcounteren
    counterMask_t sEnable;  // scounteren
  } counterCtrl_t;

endpackage

// ==== hw/perfEventSource.sv ====
// Event strobes are memory-stage pulses; counters 1 and 15 have no event source
`timescale 1ns/1ps

module perfEventSource (
  input  logic                        clk,
  input  logic                        reset,
  input  perfCounterPkg::pipeEvents_t events,
  input  perfCounterPkg::pipeCtrl_t   pipeCtrl,
  output perfCounterPkg::counterMask_t counterEvent
);
  import perfCounterPkg::*;

  logic loadStallE;  // Load stall in execute
  logic loadStallM;  // Load stall in memory
  logic validM;

  ////////////////////
  // Load-stall pipe
  ////////////////////

  // Held while execute is stalled, never flushed here
  always_ff @(posedge clk) begin
    if (reset) begin
      loadStallE <= 1'b0;
    end else if (!pipeCtrl.stallE) begin
      loadStallE <= pipeCtrl.loadStallD;
    end
  end

  // Flush at M drops the stall so it is never counted
  always_ff @(posedge clk) begin
    if (reset) begin
      loadStallM <= 1'b0;
    end else if (pipeCtrl.flushM) begin
      loadStallM <= 1'b0;
    end else if (!pipeCtrl.stallM) begin
      loadStallM <= loadStallE;
    end
  end

  ////////////////////
  // Event map
  ////////////////////
  assign validM = events.instrValidNotFlushed;

  always_comb begin
    counterEvent     = '0;
    counterEvent[0]  = 1'b1;        // mcycle
    counterEvent[1]  = 1'b0;        // No counter 1, time lives in the platform
    counterEvent[2]  = validM;      // minstret
    counterEvent[3]  = loadStallM;
    // Predictor and class events only count for retiring instructions
    counterEvent[4]  = events.dirPredWrong & validM;
    counterEvent[5]  = events.instrClass[0] & validM;  // Branch
    counterEvent[6]  = events.btbPredPcWrong & validM;
    counterEvent[7]  = (events.instrClass[4] | events.instrClass[2] |
                        events.instrClass[1]) & validM;  // Jumps, jalr, calls
    counterEvent[8]  = events.rasPredPcWrong & validM;
    counterEvent[9]  = events.instrClass[3] & validM;  // Return
    counterEvent[10] = events.classPredWrong & validM;
    // Cache strobes come straight from the caches
    counterEvent[11] = events.dCacheAccess;
    counterEvent[12] = events.dCacheMiss;
    counterEvent[13] = events.iCacheAccess;
    counterEvent[14] = events.iCacheMiss;
    counterEvent[15] = 1'b0;        // Spare
  end

endmodule

// ==== counterBank/counterBank.sv ====
// 64-bit counters kept as 32-bit halves; a CSR write beats the increment only for the half written
`timescale 1ns/1ps

module counterBank (
  input  logic                          clk,
  input  logic                          reset,
  input  perfCounterPkg::csrReq_t       csrReq,
  input  perfCounterPkg::counterMask_t  counterEvent,
  input  perfCounterPkg::counterMask_t  inhibit,
  output perfCounterPkg::csrData_t      counterLo [perfCounterPkg::NumCounters],
  output perfCounterPkg::csrData_t      counterHi [perfCounterPkg::NumCounters]
);
  import perfCounterPkg::*;

  counterMask_t countEn;  // Event and not inhibited

  assign countEn = counterEvent & ~inhibit;

  ////////////////////
  // Counter slices
  ////////////////////
  for (genvar i = 0; i < NumCounters; i++) begin : g_counter
    counterVal_t plusOne;  // Current count plus this cycle's event
    logic        writeLo;
    logic        writeHi;
    csrData_t    nextLo;
    csrData_t    nextHi;

    // Full 64-bit add so the carry reaches the high half
    assign plusOne = {counterHi[i], counterLo[i]} + counterVal_t'(countEn[i]);

    assign writeLo = csrReq.write & (csrReq.adr == csrAdr_t'(MhpmCounterBase + i));
    assign writeHi = csrReq.write & (csrReq.adr == csrAdr_t'(MhpmCounterHBase + i));

    // Written half takes the CSR data, the other keeps its part of the sum
    assign nextLo = writeLo ? csrReq.writeVal : plusOne[Xlen-1:0];
    assign nextHi = writeHi ? csrReq.writeVal : plusOne[63:Xlen];

    always_ff @(posedge clk) begin
      if (reset) begin
        counterLo[i] <= '0;
        counterHi[i] <= '0;
      end else begin
        counterLo[i] <= nextLo;
        counterHi[i] <= nextHi;
      end
    end
  end

endmodule

// ==== hw/counterControlRegs.sv ====
// Only the low NumCounters bits of each control CSR exist; upper bits read back as zero
`timescale 1ns/1ps

module counterControlRegs (
  input  logic                         clk,
  input  logic                         reset,
  input  perfCounterPkg::csrReq_t      csrReq,
  output perfCounterPkg::counterCtrl_t ctrl
);
  import perfCounterPkg::*;

  counterMask_t newVal;  // Implemented bits of the write data
  logic         writeInhibit;
  logic         writeMEn;
  logic         writeSEn;

  assign newVal = csrReq.writeVal[NumCounters-1:0];

  ////////////////////
  // Write decode
  ////////////////////
  assign writeInhibit = csrReq.write & (csrReq.adr == MCountInhibitAdr);
  assign writeMEn     = csrReq.write & (csrReq.adr == MCounterEnAdr);
  assign writeSEn     = csrReq.write & (csrReq.adr == SCounterEnAdr);

  always_ff @(posedge clk) begin
    if (reset) begin
      ctrl <= '0;  // Everything counts, nothing visible below M
    end else begin
      if (writeInhibit) ctrl.inhibit <= newVal;
      if (writeMEn)     ctrl.mEnable <= newVal;  // Opens counters to S and U
      if (writeSEn)     ctrl.sEnable <= newVal;  // Further opens them to U
    end
  end

endmodule

// ==== hw/counterReadPort.sv ====
// Combinational read of pre-edge values; counters 16-31 and unmapped addresses flag illegal
`timescale 1ns/1ps

module counterReadPort (
  input  perfCounterPkg::csrReq_t      csrReq,
  input  perfCounterPkg::counterCtrl_t ctrl,
  input  perfCounterPkg::csrData_t     counterLo [perfCounterPkg::NumCounters],
  input  perfCounterPkg::csrData_t     counterHi [perfCounterPkg::NumCounters],
  input  perfCounterPkg::counterVal_t  mtime,
  output perfCounterPkg::csrData_t     readVal,
  output logic                         illegalAccess
);
  import perfCounterPkg::*;

  logic [CounterIdxW-1:0] counterIdx;  // Counter picked by the address
  logic                   mMode;
  logic                   userEnabled; // Counteren bits let a lower mode in
  logic                   hit;         // Address is mapped here
  logic                   machineOnly;
  logic                   legal;
  csrData_t               value;

  // Address lies in a 32-entry bank and names an implemented counter
  function automatic logic inBank(csrAdr_t adr, csrAdr_t base);
    return (adr[11:5] == base[11:5]) && (adr[4:0] < 5'(NumCounters));
  endfunction

  assign counterIdx = csrReq.adr[CounterIdxW-1:0];
  assign mMode      = (csrReq.privMode == MMode);

  // S needs mcounteren only, U needs scounteren as well
  assign userEnabled = ctrl.mEnable[counterIdx] &
                       ((csrReq.privMode == SMode) | ctrl.sEnable[counterIdx]);

  ////////////////////
  // Address decode
  ////////////////////
  always_comb begin
    value       = '0;
    hit         = 1'b1;
    machineOnly = 1'b0;
    if (csrReq.adr == TimeAdr) begin              // Ahead of hpmcounter1
      value = mtime[Xlen-1:0];
    end else if (csrReq.adr == TimeHAdr) begin
      value = mtime[63:Xlen];
    end else if (inBank(csrReq.adr, HpmCounterBase)) begin
      value = counterLo[counterIdx];
    end else if (inBank(csrReq.adr, HpmCounterHBase)) begin
      value = counterHi[counterIdx];
    end else if (inBank(csrReq.adr, MhpmCounterBase)) begin
      value       = counterLo[counterIdx];
      machineOnly = 1'b1;
    end else if (inBank(csrReq.adr, MhpmCounterHBase)) begin
      value       = counterHi[counterIdx];
      machineOnly = 1'b1;
    end else if (csrReq.adr == MCountInhibitAdr) begin
      value       = csrData_t'(ctrl.inhibit);
      machineOnly = 1'b1;
    end else if (csrReq.adr == MCounterEnAdr) begin
      value       = csrData_t'(ctrl.mEnable);
      machineOnly = 1'b1;
    end else if (csrReq.adr == SCounterEnAdr) begin
      value       = csrData_t'(ctrl.sEnable);  // Machine-only in this unit
      machineOnly = 1'b1;
    end else begin
      hit = 1'b0;                                  // Not ours, or counter 16+
    end
  end

  // Privilege check, then zero the data on any failure
  assign legal         = hit & (mMode | (~machineOnly & userEnabled));
  assign readVal       = legal ? value : '0;
  assign illegalAccess = ~legal;

endmodule

// ==== hw/perfCounterTop.sv ====
// Counter CSR unit for an RV32 core; accesses are single-cycle levels with no handshake
`timescale 1ns/1ps

module perfCounterTop (
  input  logic                        clk,
  input  logic                        reset,
  input  perfCounterPkg::csrReq_t     csrReq,
  input  perfCounterPkg::pipeEvents_t events,
  input  perfCounterPkg::pipeCtrl_t   pipeCtrl,
  input  perfCounterPkg::counterVal_t mtime,     // Platform timer
  output perfCounterPkg::csrData_t    readVal,
  output logic                        illegalAccess
);
  import perfCounterPkg::*;

  counterMask_t counterEvent;              // Increment strobes
  counterCtrl_t ctrl;
  csrData_t     counterLo [NumCounters];
  csrData_t     counterHi [NumCounters];

  ////////////////////
  // Event strobes
  ////////////////////
  perfEventSource u_eventSource (
    .clk          (clk),
    .reset        (reset),
    .events       (events),
    .pipeCtrl     (pipeCtrl),
    .counterEvent (counterEvent)
  );

  counterBank u_counterBank (
    .clk          (clk),
    .reset        (reset),
    .csrReq       (csrReq),
    .counterEvent (counterEvent),
    .inhibit      (ctrl.inhibit),
    .counterLo    (counterLo),
    .counterHi    (counterHi)
  );

  counterControlRegs u_controlRegs (
    .clk    (clk),
    .reset  (reset),
    .csrReq (csrReq),
    .ctrl   (ctrl)
  );

  ////////////////////
  // CSR read side
  ////////////////////
  counterReadPort u_readPort (
    .csrReq        (csrReq),
    .ctrl          (ctrl),
    .counterLo     (counterLo),
    .counterHi     (counterHi),
    .mtime         (mtime),
    .readVal       (readVal),
    .illegalAccess (illegalAccess)
  );

endmodule

// ==== testbench/perfCounterTb.sv ====
// Needs Verilator --timing and --assert; mtime stays constant, inputs change on falling edges
`timescale 1ns/1ps

module perfCounterTb;
  import perfCounterPkg::*;

  logic         clk;
  logic         reset;
  csrReq_t      csrReq;
  pipeEvents_t  events;
  pipeCtrl_t    pipeCtrl;
  counterVal_t  mtime;         // Platform timer, fixed for the run
  csrData_t     readVal;
  logic         illegalAccess;

  pipeEvents_t  evNext;        // Applied at the next falling edge
  pipeCtrl_t    ctrlNext;
  counterVal_t  modelCnt [NumCounters];  // Reference counters
  counterMask_t modelInhibit;  // Shadow control registers
  counterMask_t modelMEn;
  counterMask_t modelSEn;
  logic         modelStallE;   // Load stall in E
  logic         modelStallM;   // Load stall in M
  int           stepErrors = 0;
  int           readErrors = 0;
  int           cycles = 0;
  csrData_t     first;
  csrData_t     second;

  perfCounterTop u_perfCounterTop (
    .clk           (clk),
    .reset         (reset),
    .csrReq        (csrReq),
    .events        (events),
    .pipeCtrl      (pipeCtrl),
    .mtime         (mtime),
    .readVal       (readVal),
    .illegalAccess (illegalAccess)
  );

  always #10 clk = ~clk;  // 20 ns period

  // Counter increment strobes as the event map defines them
  function automatic counterMask_t expectedEvents(pipeEvents_t ev, logic stallM);
    counterMask_t m;
    logic         v;
    v     = ev.instrValidNotFlushed;
    m     = '0;
    m[0]  = 1'b1;                 // Cycles
    m[2]  = v;                    // Retired
    m[3]  = stallM;
    m[4]  = v & ev.dirPredWrong;
    m[5]  = v & ev.instrClass[0];
    m[6]  = v & ev.btbPredPcWrong;
    m[7]  = v & (ev.instrClass[4] | ev.instrClass[2] | ev.instrClass[1]);
    m[8]  = v & ev.rasPredPcWrong;
    m[9]  = v & ev.instrClass[3];
    m[10] = v & ev.classPredWrong;
    m[11] = ev.dCacheAccess;
    m[12] = ev.dCacheMiss;
    m[13] = ev.iCacheAccess;
    m[14] = ev.iCacheMiss;
    return m;
  endfunction

  // Expected {illegal, data} for a read
  function automatic logic [Xlen:0] refRead(csrAdr_t adr, privMode_t mode);
    logic [4:0] idx;
    logic       inRange;
    logic       hit;
    logic       mOnly;
    logic       userOk;
    csrData_t   val;
    idx     = adr[4:0];
    inRange = !idx[4];              // Counters 16-31 do not exist
    hit     = 1'b1;
    mOnly   = 1'b0;
    val     = '0;
    userOk  = inRange && modelMEn[idx[3:0]] && (mode == SMode || modelSEn[idx[3:0]]);
    if (adr == TimeAdr) val = mtime[31:0];
    else if (adr == TimeHAdr) val = mtime[63:32];
    else if (adr[11:5] == HpmCounterBase[11:5] && inRange) val = modelCnt[idx[3:0]][31:0];
    else if (adr[11:5] == HpmCounterHBase[11:5] && inRange) val = modelCnt[idx[3:0]][63:32];
    else begin
      mOnly = 1'b1;                 // Everything else is machine level
      if (adr[11:5] == MhpmCounterBase[11:5] && inRange) val = modelCnt[idx[3:0]][31:0];
      else if (adr[11:5] == MhpmCounterHBase[11:5] && inRange) val = modelCnt[idx[3:0]][63:32];
      else if (adr == MCountInhibitAdr) val = csrData_t'(modelInhibit);
      else if (adr == MCounterEnAdr) val = csrData_t'(modelMEn);
      else if (adr == SCounterEnAdr) val = csrData_t'(modelSEn);
      else hit = 1'b0;
    end
    if (!hit || !(mode == MMode || (!mOnly && userOk))) return {1'b1, 32'h0};
    return {1'b0, val};
  endfunction

  ////////////////////
  // Reference model
  ////////////////////
  always @(posedge clk) begin : refModel
    counterMask_t ev;
    counterVal_t  sum;
    ev = expectedEvents(events, modelStallM);
    if (reset) begin
      for (int i = 0; i < NumCounters; i++) begin
        modelCnt[i] <= '0;
      end
      modelInhibit <= '0;
      modelMEn     <= '0;
      modelSEn     <= '0;
      modelStallE  <= 1'b0;
      modelStallM  <= 1'b0;
    end else begin
      for (int i = 0; i < NumCounters; i++) begin
        sum = modelCnt[i] + counterVal_t'(ev[i] & ~modelInhibit[i]);
        // A write replaces only its own half
        if (csrReq.write && csrReq.adr == MhpmCounterBase + csrAdr_t'(i))
          sum[31:0] = csrReq.writeVal;
        if (csrReq.write && csrReq.adr == MhpmCounterHBase + csrAdr_t'(i))
          sum[63:32] = csrReq.writeVal;
        modelCnt[i] <= sum;
      end
      if (!pipeCtrl.stallE) modelStallE <= pipeCtrl.loadStallD;
      if (pipeCtrl.flushM) modelStallM <= 1'b0;  // Flushed stall never counts
      else if (!pipeCtrl.stallM) modelStallM <= modelStallE;
      if (csrReq.write && csrReq.adr == MCountInhibitAdr) modelInhibit <= csrReq.writeVal[15:0];
      if (csrReq.write && csrReq.adr == MCounterEnAdr) modelMEn <= csrReq.writeVal[15:0];
      if (csrReq.write && csrReq.adr == SCounterEnAdr) modelSEn <= csrReq.writeVal[15:0];
    end
  end

  ////////////////////
  // Checkers
  ////////////////////
  always @(negedge clk) begin : readCheck
    logic [Xlen:0] exp;
    #3;                             // Inputs settled, before the next edge
    exp = refRead(csrReq.adr, csrReq.privMode);
    if (!reset) begin
      assert (readVal === exp[Xlen-1:0]) else begin
        readErrors++;
        $display("Fail readVal at adr %h: got %h expected %h", csrReq.adr, readVal, exp[31:0]);
      end
      assert (illegalAccess === exp[Xlen]) else begin
        readErrors++;
        $display("Fail illegalAccess at adr %h: got %h expected %h",
                 csrReq.adr, illegalAccess, exp[Xlen]);
      end
    end
  end

  // Checks against a value fixed by the directed sequence
  task automatic expectRead(input csrData_t expVal, input logic expIllegal);
    assert (readVal === expVal) else begin
      stepErrors++;
      $display("Fail readVal at adr %h: got %h expected %h", csrReq.adr, readVal, expVal);
    end
    assert (illegalAccess === expIllegal) else begin
      stepErrors++;
      $display("Fail illegalAccess at adr %h: got %h expected %h",
               csrReq.adr, illegalAccess, expIllegal);
    end
  endtask

  // One cycle of stimulus, applied at the falling edge
  task automatic driveReq(input logic wr, input csrAdr_t adr, input csrData_t val,
                          input privMode_t mode);
    @(negedge clk);
    csrReq.write    = wr;
    csrReq.adr      = adr;
    csrReq.writeVal = val;
    csrReq.privMode = mode;
    events          = evNext;
    pipeCtrl        = ctrlNext;
    #4;                             // Past the read checker
  endtask

  task automatic randomRun(input int n, input logic withStalls);
    logic [31:0] rnd;
    csrAdr_t     adr;
    for (int k = 0; k < n; k++) begin
      rnd    = $urandom;
      evNext = rnd[$bits(pipeEvents_t)-1:0];
      if (withStalls) begin
        rnd      = $urandom;
        ctrlNext = rnd[$bits(pipeCtrl_t)-1:0];
      end
      adr = withStalls ? HpmCounterBase + 12'd3 : HpmCounterBase + csrAdr_t'(k % 16);
      driveReq(1'b0, adr, '0, MMode);
    end
    evNext   = '0;
    ctrlNext = '0;
  endtask

  ////////////////////
  // Stimulus
  ////////////////////
  initial begin
    void'($urandom(61178));
    clk      = 1'b0;
    reset    = 1'b1;
    csrReq   = '0;
    events   = '0;
    pipeCtrl = '0;
    evNext   = '0;
    ctrlNext = '0;
    mtime    = {$urandom, $urandom};
    repeat (16) @(negedge clk);
    reset = 1'b0;

    // Reset values
    driveReq(1'b0, MCountInhibitAdr, '0, MMode);
    expectRead('0, 1'b0);
    driveReq(1'b0, MCounterEnAdr, '0, MMode);
    expectRead('0, 1'b0);
    driveReq(1'b0, SCounterEnAdr, '0, MMode);
    expectRead('0, 1'b0);
    for (int i = 1; i < NumCounters; i++) begin
      driveReq(1'b0, MhpmCounterBase + csrAdr_t'(i), '0, MMode);
      expectRead('0, 1'b0);
    end
    driveReq(1'b0, MhpmCounterBase, '0, MMode);
    first = readVal;
    repeat (7) driveReq(1'b0, MhpmCounterBase, '0, MMode);
    second = readVal;
    assert (second - first == 32'd7) else begin
      stepErrors++;
      $display("Fail mcycle delta: got %h expected %h", second - first, 32'd7);
    end

    // Write priority and carry into the high half
    driveReq(1'b1, MhpmCounterHBase, 32'h5, MMode);
    driveReq(1'b1, MhpmCounterBase, 32'hFFFF_FFFE, MMode);
    driveReq(1'b0, MhpmCounterBase, '0, MMode);
    expectRead(32'hFFFF_FFFE, 1'b0);  // Write beat the cycle increment
    driveReq(1'b0, MhpmCounterHBase, '0, MMode);
    expectRead(32'h5, 1'b0);
    driveReq(1'b0, MhpmCounterHBase, '0, MMode);
    expectRead(32'h6, 1'b0);          // Low half wrapped
    driveReq(1'b0, MhpmCounterBase, '0, MMode);
    expectRead(32'h1, 1'b0);

    // Random events, then every event counter
    randomRun(500, 1'b0);
    for (int i = 2; i < 15; i++) begin
      driveReq(1'b0, HpmCounterBase + csrAdr_t'(i), '0, MMode);
      expectRead(modelCnt[i][31:0], 1'b0);
    end

    // Load-stall pipeline with random stalls and flushes
    randomRun(500, 1'b1);
    driveReq(1'b0, HpmCounterBase + 12'd3, '0, MMode);
    expectRead(modelCnt[3][31:0], 1'b0);

    // Inhibit freezes minstret only
    evNext.instrValidNotFlushed = 1'b1;
    driveReq(1'b1, MCountInhibitAdr, 32'h4, MMode);
    driveReq(1'b0, HpmCounterBase + 12'd2, '0, MMode);
    first = readVal;
    repeat (20) driveReq(1'b0, HpmCounterBase, '0, MMode);  // mcycle still moves
    driveReq(1'b0, HpmCounterBase + 12'd2, '0, MMode);
    second = readVal;
    assert (second == first) else begin
      stepErrors++;
      $display("Fail minstret while inhibited: got %h expected %h", second, first);
    end
    driveReq(1'b1, MCountInhibitAdr, 32'h0, MMode);
    repeat (10) driveReq(1'b0, HpmCounterBase + 12'd2, '0, MMode);
    expectRead(second + 32'd9, 1'b0);
    evNext = '0;

    // Privilege and decode
    driveReq(1'b0, HpmCounterBase + 12'd3, '0, UMode);
    expectRead('0, 1'b1);
    driveReq(1'b1, MCounterEnAdr, 32'h8, MMode);
    driveReq(1'b0, HpmCounterBase + 12'd3, '0, SMode);
    expectRead(modelCnt[3][31:0], 1'b0);
    driveReq(1'b0, HpmCounterBase + 12'd3, '0, UMode);
    expectRead('0, 1'b1);             // scounteren still closed
    driveReq(1'b1, SCounterEnAdr, 32'h8, MMode);
    driveReq(1'b0, HpmCounterBase + 12'd3, '0, UMode);
    expectRead(modelCnt[3][31:0], 1'b0);
    driveReq(1'b0, MhpmCounterBase + 12'd3, '0, SMode);
    expectRead('0, 1'b1);
    driveReq(1'b0, MCountInhibitAdr, '0, UMode);
    expectRead('0, 1'b1);
    driveReq(1'b0, 12'h7C0, '0, MMode);
    expectRead('0, 1'b1);             // Unmapped
    driveReq(1'b0, MhpmCounterBase + 12'd16, '0, MMode);
    expectRead('0, 1'b1);             // Counter 16 does not exist
    driveReq(1'b0, TimeAdr, '0, MMode);
    expectRead(mtime[31:0], 1'b0);
    driveReq(1'b0, TimeHAdr, '0, MMode);
    expectRead(mtime[63:32], 1'b0);

    $display("Run complete with %0d directed errors and %0d read errors",
             stepErrors, readErrors);
    if (stepErrors + readErrors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // About 1100 cycles of tests, limit leaves ample margin
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= 3000) begin
      $display("Timeout after %0d cycles with %0d errors", cycles,
               stepErrors + readErrors);
      $display("*** FAILED ***");
      $finish;
    end
  end

endmodule

// ==== perfCounter.f ====
common/perfCounterPkg.sv
hw/perfEventSource.sv
counterBank/counterBank.sv
hw/counterControlRegs.sv
hw/counterReadPort.sv
hw/perfCounterTop.sv
testbench/perfCounterTb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -f perfCounter.f --top-module perfCounterTb -Mdir obj_dir
	./obj_dir/VperfCounterTb | tee sim.log
	@if grep -q "\*\*\* FAILED \*\*\*" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "\*\*\* PASSED \*\*\*" sim.log || (echo "No pass line in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
